// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR,
        ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_PASS_B,  // LHI
        ALU_OR_B     // ORI, zero-extends the low byte of b
    } alu_op_e;

    // ADD r0,r0,r0 in bubble slots, never valid
    localparam word_t NOP_INST = 16'hf000;

    //////////////////////////////////////////////////
    // Instruction fields

    function automatic opcode_e get_opcode(word_t inst);
        return opcode_e'(inst[15:12]);
    endfunction

    function automatic reg_idx_t get_rs(word_t inst);
        return inst[11:10];
    endfunction

    function automatic reg_idx_t get_rt(word_t inst);
        return inst[9:8];
    endfunction

    function automatic reg_idx_t get_rd(word_t inst);
        return inst[7:6];
    endfunction

    function automatic func_e get_func(word_t inst);
        return func_e'(inst[5:0]);
    endfunction

    function automatic logic [7:0] get_imm(word_t inst);
        return inst[7:0];
    endfunction

    function automatic logic [11:0] get_target(word_t inst);
        return inst[11:0];
    endfunction

endpackage

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // Forward selects for the EX operands
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_WB   = 2'd1;
    localparam logic [1:0] FWD_MEM  = 2'd2;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    dest_is_rd;   // else rt
        logic    is_branch_eq;
        logic    is_branch_ne;
        logic    is_jump;
        logic    is_wwd;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    pc;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm_ext;
        word_t    jump_target;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    alu_out;
        word_t    store_val;
        reg_idx_t dest;
        word_t    wwd_val;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    result;
        reg_idx_t dest;
        word_t    wwd_val;
    } mem_wb_t;

endpackage

// ==== rtl/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder import isa_pkg::*, pipe_pkg::*; (
    input  word_t inst,
    output ctrl_t ctrl
);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_ADD;
        case (get_opcode(inst))
            OP_RTYPE: begin
                ctrl.reg_write  = 1'b1;
                ctrl.dest_is_rd = 1'b1;
                case (get_func(inst))
                    FN_ADD: ctrl.alu_op = ALU_ADD;
                    FN_SUB: ctrl.alu_op = ALU_SUB;
                    FN_AND: ctrl.alu_op = ALU_AND;
                    FN_ORR: ctrl.alu_op = ALU_ORR;
                    FN_NOT: ctrl.alu_op = ALU_NOT;
                    FN_TCP: ctrl.alu_op = ALU_TCP;
                    FN_SHL: ctrl.alu_op = ALU_SHL;
                    FN_SHR: ctrl.alu_op = ALU_SHR;
                    FN_WWD: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_wwd    = 1'b1;
                    end
                    FN_HLT: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_halt   = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;  // Unused func codes
                endcase
            end
            OP_ADI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_ORI: begin
                ctrl.alu_op      = ALU_OR_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_LHI: begin
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_LWD: begin
                ctrl.alu_src_imm = 1'b1;  // Address is rs + imm
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_SWD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ: ctrl.is_branch_eq = 1'b1;
            OP_BNE: ctrl.is_branch_ne = 1'b1;
            OP_JMP: ctrl.is_jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rd_addr_a,
    input  reg_idx_t rd_addr_b,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // WB write seen by ID in the same cycle
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import isa_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    always_comb begin
        case (op)
            ALU_ADD:    y = a + b;
            ALU_SUB:    y = a - b;
            ALU_AND:    y = a & b;
            ALU_ORR:    y = a | b;
            ALU_NOT:    y = ~a;
            ALU_TCP:    y = ~a + 16'd1;
            ALU_SHL:    y = {a[14:0], 1'b0};
            ALU_SHR:    y = {a[15], a[15:1]};  // Arithmetic
            ALU_PASS_B: y = b;
            ALU_OR_B:   y = a | {8'h00, b[7:0]};
            default:    y = '0;
        endcase
    end

endmodule

// ==== rtl/hazard_forward.sv ====
`timescale 1ns/1ps

module hazard_forward import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    input  reg_idx_t   if_rs,
    input  reg_idx_t   if_rt,
    input  logic       if_valid,
    input  logic       branch_taken,
    output logic       stall,
    output logic       flush,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    reg_idx_t ex_dest;
    logic     load_in_ex;
    logic     mem_writes;
    logic     wb_writes;

    // Younger result wins
    function automatic logic [1:0] pick(reg_idx_t src);
        if (mem_writes && ex_mem.dest == src) begin
            return FWD_MEM;
        end
        if (wb_writes && mem_wb.dest == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign ex_dest    = id_ex.ctrl.dest_is_rd ? id_ex.rd : id_ex.rt;
    assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_read;
    assign mem_writes = ex_mem.valid && ex_mem.ctrl.reg_write;
    assign wb_writes  = mem_wb.valid && mem_wb.ctrl.reg_write;

    assign flush = branch_taken;
    assign stall = !flush && if_valid && load_in_ex && (ex_dest == if_rs || ex_dest == if_rt);

    always_comb begin
        fwd_a = pick(id_ex.rs);
        fwd_b = pick(id_ex.rt);
    end

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import isa_pkg::*; #(
    parameter int DMEM_ADDR_BITS = 8
) (
    input  logic  clk,
    input  logic  wr_en,
    input  word_t addr,
    input  word_t wr_data,
    output word_t rd_data
);

    localparam int DEPTH = 1 << DMEM_ADDR_BITS;

    word_t mem [DEPTH] = '{default: '0};
    logic [DMEM_ADDR_BITS-1:0] index;

    assign index   = addr[DMEM_ADDR_BITS-1:0];
    assign rd_data = mem[index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[index] <= wr_data;
        end
    end

    // Upper address bits would silently alias
    assert property (@(posedge clk) wr_en |-> (addr >> DMEM_ADDR_BITS) == '0)
        else $error("data_memory: store address %h out of range", addr);

endmodule

// ==== rtl/cpu_pipeline.sv ====
`timescale 1ns/1ps

module cpu_pipeline import isa_pkg::*, pipe_pkg::*; #(
    parameter int DMEM_ADDR_BITS = 8
) (
    input  logic  clk,
    input  logic  reset_n,
    input  word_t inst_data,
    output word_t inst_addr,
    output word_t output_port,
    output logic  wwd_strobe,
    output word_t num_inst,
    output logic  is_halted
);

    word_t       pc;
    word_t       if_inst;
    word_t       if_pc;
    logic        if_valid;
    logic        halt_latched;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    mem_wb_t     mem_wb;

    ctrl_t       dec_ctrl;
    reg_idx_t    id_rs;
    reg_idx_t    id_rt;
    logic [7:0]  imm8;
    word_t       imm_ext;
    word_t       rf_a;
    word_t       rf_b;
    logic        halt_in_id;
    logic        fetch_en;

    logic        stall;
    logic        flush;
    logic        branch_taken;
    logic [1:0]  fwd_a;
    logic [1:0]  fwd_b;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_b;
    word_t       alu_y;
    word_t       branch_target;
    word_t       dmem_rd;

    function automatic word_t fwd_mux(logic [1:0] sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // IF

    assign inst_addr  = pc;
    assign halt_in_id = if_valid && dec_ctrl.is_halt;
    assign fetch_en   = !halt_latched && !halt_in_id;  // Nothing fetched past HLT

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc           <= '0;
            if_valid     <= 1'b0;
            if_inst      <= NOP_INST;
            halt_latched <= 1'b0;
        end else if (flush) begin
            pc       <= branch_target;
            if_valid <= 1'b0;
            if_inst  <= NOP_INST;
        end else if (!stall) begin
            if (fetch_en) begin
                pc       <= pc + 16'd1;
                if_inst  <= inst_data;
                if_pc    <= pc;
                if_valid <= 1'b1;
            end else begin
                if_valid <= 1'b0;
                if_inst  <= NOP_INST;
            end
            if (halt_in_id) begin
                halt_latched <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // ID

    assign id_rs   = get_rs(if_inst);
    assign id_rt   = get_rt(if_inst);
    assign imm8    = get_imm(if_inst);
    assign imm_ext = (get_opcode(if_inst) == OP_LHI) ? {imm8, 8'h00} : {{8{imm8[7]}}, imm8};

    control_decoder u_dec (
        .inst (if_inst),
        .ctrl (dec_ctrl)
    );

    register_file u_rf (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_addr_a (id_rs),
        .rd_addr_b (id_rt),
        .wr_en     (mem_wb.valid && mem_wb.ctrl.reg_write),
        .wr_addr   (mem_wb.dest),
        .wr_data   (mem_wb.result),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid       <= if_valid && !stall && !flush;  // Bubble on either
            id_ex.ctrl        <= dec_ctrl;
            id_ex.pc          <= if_pc;
            id_ex.rs          <= id_rs;
            id_ex.rt          <= id_rt;
            id_ex.rd          <= get_rd(if_inst);
            id_ex.rs_val      <= rf_a;
            id_ex.rt_val      <= rf_b;
            id_ex.imm_ext     <= imm_ext;
            id_ex.jump_target <= {if_pc[15:12], get_target(if_inst)};
        end
    end

    //////////////////////////////////////////////////
    // EX

    hazard_forward u_haz (
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .if_rs        (id_rs),
        .if_rt        (id_rt),
        .if_valid     (if_valid),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

    assign op_a  = fwd_mux(fwd_a, id_ex.rs_val, ex_mem.alu_out, mem_wb.result);
    assign op_b  = fwd_mux(fwd_b, id_ex.rt_val, ex_mem.alu_out, mem_wb.result);
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm_ext : op_b;

    alu u_alu (
        .op (id_ex.ctrl.alu_op),
        .a  (op_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    assign branch_taken = id_ex.valid && ((id_ex.ctrl.is_branch_eq && op_a == op_b) ||
                                          (id_ex.ctrl.is_branch_ne && op_a != op_b) ||
                                          id_ex.ctrl.is_jump);
    assign branch_target = id_ex.ctrl.is_jump ? id_ex.jump_target
                                              : id_ex.pc + 16'd1 + id_ex.imm_ext;

    //////////////////////////////////////////////////
    // MEM and WB

    data_memory #(
        .DMEM_ADDR_BITS (DMEM_ADDR_BITS)
    ) u_dmem (
        .clk     (clk),
        .wr_en   (ex_mem.valid && ex_mem.ctrl.mem_write),
        .addr    (ex_mem.alu_out),
        .wr_data (ex_mem.store_val),
        .rd_data (dmem_rd)
    );

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else begin
            ex_mem.valid     <= id_ex.valid;
            ex_mem.ctrl      <= id_ex.ctrl;
            ex_mem.alu_out   <= alu_y;
            ex_mem.store_val <= op_b;
            ex_mem.dest      <= id_ex.ctrl.dest_is_rd ? id_ex.rd : id_ex.rt;
            ex_mem.wwd_val   <= op_a;

            mem_wb.valid   <= ex_mem.valid;
            mem_wb.ctrl    <= ex_mem.ctrl;
            mem_wb.result  <= ex_mem.ctrl.mem_read ? dmem_rd : ex_mem.alu_out;
            mem_wb.dest    <= ex_mem.dest;
            mem_wb.wwd_val <= ex_mem.wwd_val;
        end
    end

    // Loaded on the edge into WB, so they line up with the retiring entry
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            wwd_strobe  <= 1'b0;
            is_halted   <= 1'b0;
        end else begin
            wwd_strobe <= ex_mem.valid && ex_mem.ctrl.is_wwd;
            if (ex_mem.valid) begin
                num_inst <= num_inst + 16'd1;
            end
            if (ex_mem.valid && ex_mem.ctrl.is_wwd) begin
                output_port <= ex_mem.wwd_val;
            end
            if (ex_mem.valid && ex_mem.ctrl.is_halt) begin
                is_halted <= 1'b1;  // Sticky until reset
            end
        end
    end

    // Bubble behind a load clears the hazard
    assert property (@(posedge clk) disable iff (reset_n) stall |=> !stall)
        else $error("cpu_pipeline: stall held for two cycles");

    assert property (@(posedge clk) disable iff (reset_n)
        id_ex.valid |-> !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write))
        else $error("cpu_pipeline: load and store decoded together");

endmodule

// ==== include/tb_asm.svh ====
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// Encoders, included after isa_pkg is imported

function automatic word_t asm_r(func_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    return {OP_RTYPE, rs, rt, rd, fn};
endfunction

function automatic word_t asm_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
    return {op, rs, rt, imm};  // ADI, ORI, LHI, LWD, SWD, BEQ, BNE
endfunction

function automatic word_t asm_jmp(logic [11:0] target);
    return {OP_JMP, target};
endfunction

function automatic word_t asm_wwd(reg_idx_t rs);
    return asm_r(FN_WWD, rs, 2'd0, 2'd0);
endfunction

function automatic word_t asm_hlt();
    return asm_r(FN_HLT, 2'd0, 2'd0, 2'd0);
endfunction

`endif

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*; ();

    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 40;

    logic  clk;
    logic  reset_n;
    word_t inst_data;
    word_t inst_addr;
    word_t output_port;
    logic  wwd_strobe;
    word_t num_inst;
    logic  is_halted;

    word_t       imem [256];
    logic [7:0]  prog_len;
    word_t       port_log [$];
    word_t       expected [$];
    logic [31:0] lfsr_state;

    `include "tb_asm.svh"

    cpu_pipeline #(
        .DMEM_ADDR_BITS (8)
    ) UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst_data   (inst_data),
        .inst_addr   (inst_addr),
        .output_port (output_port),
        .wwd_strobe  (wwd_strobe),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    // Instruction ROM, NOP past the end
    assign inst_data = (inst_addr < 16'd256) ? imem[inst_addr[7:0]] : NOP_INST;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////
    // Checks

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers

    // Galois form, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = NOP_INST;
        end
        prog_len = 8'd0;
        expected.delete();
    endtask

    task automatic put_inst(word_t w);
        imem[prog_len] = w;
        prog_len = prog_len + 8'd1;
    endtask

    task automatic put_wwd(reg_idx_t rs, word_t value);
        put_inst(asm_wwd(rs));
        expected.push_back(value);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #2 reset_n = 1'b1;
        repeat (10) @(posedge clk);
        #2 reset_n = 1'b0;
        port_log.delete();
    endtask

    task automatic collect_outputs();
        while (!is_halted) begin
            @(posedge clk);
            #1;
            if (wwd_strobe) begin
                port_log.push_back(output_port);
            end
        end
    endtask

    task automatic compare_outputs(word_t exp_count);
        check_count("output_port writes", word_t'(port_log.size()),
                    word_t'(expected.size()));
        foreach (expected[i]) begin
            check_word("output_port", port_log[i], expected[i]);
        end
        check_count("num_inst", num_inst, exp_count);
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_state();
        clear_program();
        put_inst(asm_i(OP_LHI, 2'd0, 2'd2, 8'h5a));
        put_inst(asm_i(OP_ORI, 2'd2, 2'd2, 8'hc3));
        put_inst(asm_i(OP_ADI, 2'd2, 2'd2, 8'h01));
        put_wwd(2'd2, 16'h5ac4);
        put_inst(asm_hlt());
        pulse_reset();
        check_word("inst_addr", inst_addr, 16'h0000);
        check_word("output_port", output_port, 16'h0000);
        check_count("num_inst", num_inst, 16'd0);
        check_flag("is_halted", is_halted, 1'b0);
        check_flag("wwd_strobe", wwd_strobe, 1'b0);
        while (!wwd_strobe && !is_halted) begin
            check_word("output_port", output_port, 16'h0000);
            @(posedge clk);
            #1;
        end
        if (wwd_strobe) begin
            check_count("num_inst", num_inst, 16'd4);  // WWD is the 4th to retire
            port_log.push_back(output_port);
        end
        collect_outputs();
        compare_outputs(word_t'(prog_len));
    endtask

    task automatic test_alu_forwarding();
        word_t r0;
        word_t r1;
        word_t r2;
        word_t r3;
        clear_program();
        r1 = 16'h1200;
        put_inst(asm_i(OP_LHI, 2'd0, 2'd1, 8'h12));
        r1 = r1 | 16'h0034;
        put_inst(asm_i(OP_ORI, 2'd1, 2'd1, 8'h34));
        put_wwd(2'd1, r1);
        r2 = r1 + 16'hfff0;  // Negative immediate
        put_inst(asm_i(OP_ADI, 2'd1, 2'd2, 8'hf0));
        put_wwd(2'd2, r2);
        r3 = 16'h8005;
        put_inst(asm_i(OP_LHI, 2'd0, 2'd3, 8'h80));
        put_inst(asm_i(OP_ORI, 2'd3, 2'd3, 8'h05));
        put_wwd(2'd3, r3);
        r0 = r1 + r2;
        put_inst(asm_r(FN_ADD, 2'd1, 2'd2, 2'd0));
        put_wwd(2'd0, r0);
        r0 = r0 - r3;
        put_inst(asm_r(FN_SUB, 2'd0, 2'd3, 2'd0));
        put_wwd(2'd0, r0);
        r2 = r0 & r1;
        put_inst(asm_r(FN_AND, 2'd0, 2'd1, 2'd2));
        put_wwd(2'd2, r2);
        r2 = r2 | r3;
        put_inst(asm_r(FN_ORR, 2'd2, 2'd3, 2'd2));
        put_wwd(2'd2, r2);
        r0 = ~r2;
        put_inst(asm_r(FN_NOT, 2'd2, 2'd0, 2'd0));
        put_wwd(2'd0, r0);
        r0 = 16'h0000 - r0;
        put_inst(asm_r(FN_TCP, 2'd0, 2'd0, 2'd0));
        put_wwd(2'd0, r0);
        r1 = r0 << 1;
        put_inst(asm_r(FN_SHL, 2'd0, 2'd0, 2'd1));
        put_wwd(2'd1, r1);
        r1 = word_t'($signed(r3) >>> 1);
        put_inst(asm_r(FN_SHR, 2'd3, 2'd0, 2'd1));
        put_wwd(2'd1, r1);
        put_inst(asm_hlt());
        pulse_reset();
        collect_outputs();
        compare_outputs(word_t'(prog_len));
    endtask

    task automatic test_random_chain();
        logic [7:0] c;
        word_t      r1;
        word_t      r2;
        word_t      r3;
        clear_program();
        r1 = 16'h0000;
        r3 = 16'h0000;
        draw_byte(c);
        r2 = {{8{c[7]}}, c};
        put_inst(asm_i(OP_ADI, 2'd0, 2'd2, c));
        for (int k = 0; k < 6; k++) begin
            draw_byte(c);
            r1 = r1 + {{8{c[7]}}, c};
            put_inst(asm_i(OP_ADI, 2'd1, 2'd1, c));
            put_wwd(2'd1, r1);
            r2 = r2 + r1;
            put_inst(asm_r(FN_ADD, 2'd2, 2'd1, 2'd2));
            r3 = r3 - r2;
            put_inst(asm_r(FN_SUB, 2'd3, 2'd2, 2'd3));
            put_wwd(2'd3, r3);
        end
        put_inst(asm_hlt());
        pulse_reset();
        collect_outputs();
        compare_outputs(word_t'(prog_len));
    endtask

    task automatic test_load_use();
        word_t r0;
        word_t r1;
        word_t r2;
        clear_program();
        r1 = 16'ha53c;
        r2 = 16'h0010;
        put_inst(asm_i(OP_LHI, 2'd0, 2'd1, 8'ha5));
        put_inst(asm_i(OP_ORI, 2'd1, 2'd1, 8'h3c));
        put_inst(asm_i(OP_ADI, 2'd0, 2'd2, 8'h10));
        put_inst(asm_i(OP_SWD, 2'd2, 2'd1, 8'h04));   // mem[0x14] = r1
        put_inst(asm_i(OP_LWD, 2'd2, 2'd3, 8'h04));
        r0 = r1 + r1;
        put_inst(asm_r(FN_ADD, 2'd3, 2'd1, 2'd0));    // Uses the load at once
        put_wwd(2'd0, r0);
        put_inst(asm_i(OP_LWD, 2'd2, 2'd3, 8'h04));
        put_wwd(2'd3, r1);
        put_inst(asm_i(OP_SWD, 2'd2, 2'd0, 8'hfe));   // mem[0x0e] = r0
        put_inst(asm_i(OP_LWD, 2'd2, 2'd1, 8'hfe));
        r1 = r0 + r2;
        put_inst(asm_r(FN_ADD, 2'd1, 2'd2, 2'd1));
        put_wwd(2'd1, r1);
        put_inst(asm_hlt());
        pulse_reset();
        collect_outputs();
        compare_outputs(word_t'(prog_len));
    endtask

    task automatic test_control_flow();
        clear_program();
        put_inst(asm_i(OP_ADI, 2'd0, 2'd1, 8'd5));
        put_inst(asm_i(OP_ADI, 2'd0, 2'd2, 8'd5));
        put_inst(asm_i(OP_BEQ, 2'd1, 2'd2, 8'd2));    // Taken, to 5
        put_inst(asm_wwd(2'd1));
        put_inst(asm_wwd(2'd2));
        put_inst(asm_i(OP_ADI, 2'd0, 2'd3, 8'h11));
        put_wwd(2'd3, 16'h0011);
        put_inst(asm_i(OP_BNE, 2'd1, 2'd2, 8'd1));    // Falls through
        put_inst(asm_i(OP_ADI, 2'd3, 2'd3, 8'h01));
        put_wwd(2'd3, 16'h0012);
        put_inst(asm_jmp(12'd14));
        put_inst(asm_wwd(2'd1));
        put_inst(asm_wwd(2'd2));
        put_inst(asm_hlt());
        put_inst(asm_i(OP_ADI, 2'd0, 2'd0, 8'h7f));  // 14
        put_wwd(2'd0, 16'h007f);
        put_inst(asm_hlt());
        pulse_reset();
        collect_outputs();
        compare_outputs(16'd12);
    endtask

    task automatic test_halt_count();
        clear_program();
        put_inst(asm_i(OP_ADI, 2'd0, 2'd1, 8'd3));
        put_inst(asm_i(OP_ADI, 2'd1, 2'd1, 8'hff));
        put_inst(asm_i(OP_BNE, 2'd1, 2'd0, 8'hfe));   // Back to 1 while r1 != 0
        put_wwd(2'd1, 16'h0000);
        put_inst(asm_hlt());
        pulse_reset();
        collect_outputs();
        compare_outputs(16'd9);
        // Nothing retires once halted
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag("wwd_strobe", wwd_strobe, 1'b0);
            check_count("num_inst", num_inst, 16'd9);
            check_flag("is_halted", is_halted, 1'b1);
        end
    endtask

    initial begin
        reset_n     = 1'b1;
        lfsr_state  = 32'hbd62_a305;
        clear_program();

        test_reset_state();
        test_alu_forwarding();
        test_random_chain();
        test_load_use();
        test_control_flow();
        test_halt_count();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/control_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_forward.sv
rtl/data_memory.sv
rtl/cpu_pipeline.sv
tests/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f sim.f -o Vtb_cpu

sim_out=$(./obj_dir/Vtb_cpu 2>&1) || true
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
